/* logic/instDecoder.sv */
`include "rvCore_settings.svh"

module instDecoder (
  input  rvCorePkg::instWordU    inst,
  output rvCorePkg::ctrlS        ctrl,
  output logic [`XLEN-1:0]       imm,
  output logic [`REG_IDX_W-1:0]  rs1,
  output logic [`REG_IDX_W-1:0]  rs2,
  output logic [`REG_IDX_W-1:0]  rd
);
  import rvCorePkg::*;

  // retires as a no-op: no write, no store, pc+4
  localparam ctrlS nopCtrl = '{
    aluOp:       aluAdd,
    srcAPc:      1'b0,
    srcBImm:     1'b0,
    brKind:      brNone,
    wbSel:       wbAlu,
    regWrite:    1'b0,
    memRead:     1'b0,
    memWrite:    1'b0,
    memSize:     memDouble,
    memUnsigned: 1'b0
  };

  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;
  logic [6:0]       funct7;
  aluF3E            aluF3;
  logic             legal;

  function automatic aluOpE aluOpFor(input aluF3E f3, input logic alt);
    aluOpE op;
    case (f3)
      f3AddSub: op = alt ? aluSub : aluAdd;
      f3Sll:    op = aluSll;
      f3Slt:    op = aluSlt;
      f3Sltu:   op = aluSltu;
      f3Xor:    op = aluXor;
      f3SrlSra: op = alt ? aluSra : aluSrl;
      f3Or:     op = aluOr;
      f3And:    op = aluAnd;
    endcase
    return op;
  endfunction

  assign rs1    = inst.r.rs1;
  assign rs2    = inst.r.rs2;
  assign rd     = inst.r.rd;
  assign funct7 = inst.r.funct7;
  assign aluF3  = aluF3E'(inst.r.funct3);

  assign immI = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  assign immS = {{(`XLEN-12){inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
  assign immB = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10to5,
                 inst.b.imm4to1, 1'b0};
  assign immU = {{(`XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
  assign immJ = {{(`XLEN-20){inst.j.imm20}}, inst.j.imm19to12, inst.j.imm11,
                 inst.j.imm10to1, 1'b0};

  always_comb begin
    ctrl  = nopCtrl;
    imm   = '0;
    legal = 1'b1;
    case (opcodeE'(inst.r.opcode))
      opLui: begin
        ctrl.aluOp    = aluPassB;
        ctrl.srcBImm  = 1'b1;
        ctrl.regWrite = 1'b1;
        imm           = immU;
      end
      opAuipc: begin
        ctrl.srcAPc   = 1'b1;
        ctrl.srcBImm  = 1'b1;
        ctrl.regWrite = 1'b1;
        imm           = immU;
      end
      opJal: begin
        ctrl.brKind   = brJal;
        ctrl.wbSel    = wbPcPlus4;
        ctrl.regWrite = 1'b1;
        imm           = immJ;
      end
      opJalr: begin
        legal         = inst.i.funct3 == 3'b000;
        ctrl.srcBImm  = 1'b1;
        ctrl.brKind   = brJalr;
        ctrl.wbSel    = wbPcPlus4;
        ctrl.regWrite = 1'b1;
        imm           = immI;
      end
      opBranch: begin
        // rs1 - rs2 feeds the compare flags
        ctrl.aluOp = aluSub;
        imm        = immB;
        case (brF3E'(inst.b.funct3))
          f3Beq:   ctrl.brKind = brEq;
          f3Bne:   ctrl.brKind = brNe;
          f3Blt:   ctrl.brKind = brLt;
          f3Bge:   ctrl.brKind = brGe;
          f3Bltu:  ctrl.brKind = brLtu;
          f3Bgeu:  ctrl.brKind = brGeu;
          default: legal = 1'b0;
        endcase
      end
      opLoad: begin
        // no unsigned doubleword load
        legal            = inst.i.funct3 != 3'b111;
        ctrl.srcBImm     = 1'b1;
        ctrl.wbSel       = wbLoad;
        ctrl.regWrite    = 1'b1;
        ctrl.memRead     = 1'b1;
        ctrl.memSize     = memSizeE'(inst.i.funct3[1:0]);
        ctrl.memUnsigned = inst.i.funct3[2];
        imm              = immI;
      end
      opStore: begin
        legal         = !inst.s.funct3[2];
        ctrl.srcBImm  = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.memSize  = memSizeE'(inst.s.funct3[1:0]);
        imm           = immS;
      end
      opImm: begin
        ctrl.aluOp    = aluOpFor(aluF3, aluF3 == f3SrlSra && funct7[5]);
        ctrl.srcBImm  = 1'b1;
        ctrl.regWrite = 1'b1;
        imm           = immI;
        // shamt takes imm[5:0], the rest must be 0 or the SRAI pattern
        if (aluF3 == f3Sll) begin
          legal = funct7[6:1] == 6'b000000;
        end else if (aluF3 == f3SrlSra) begin
          legal = funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000;
        end
      end
      opReg: begin
        legal = funct7 == 7'b0000000 ||
                (funct7 == 7'b0100000 && (aluF3 == f3AddSub || aluF3 == f3SrlSra));
        ctrl.aluOp    = aluOpFor(aluF3, funct7[5]);
        ctrl.regWrite = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      ctrl = nopCtrl;
    end
  end

endmodule

/* logic/intAlu.sv */
`include "rvCore_settings.svh"

module intAlu (
  input  rvCorePkg::ctrlS     ctrl,
  input  logic [`XLEN-1:0]    pc,
  input  logic [`XLEN-1:0]    rs1Data,
  input  logic [`XLEN-1:0]    rs2Data,
  input  logic [`XLEN-1:0]    imm,
  output logic [`XLEN-1:0]    result,
  output rvCorePkg::cmpFlagsS flags
);
  import rvCorePkg::*;

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] opBInv;
  logic [`XLEN:0]   subWide;
  logic [`XLEN-1:0] diff;
  logic             carry;
  logic             overflow;
  logic [5:0]       shamt;

  assign opA    = ctrl.srcAPc ? pc : rs1Data;
  assign opB    = ctrl.srcBImm ? imm : rs2Data;
  assign opBInv = ~opB;
  assign shamt  = opB[5:0];

  // a + ~b + 1, carry out set means no borrow
  assign subWide  = {1'b0, opA} + {1'b0, opBInv} + {{`XLEN{1'b0}}, 1'b1};
  assign diff     = subWide[`XLEN-1:0];
  assign carry    = subWide[`XLEN];
  assign overflow = (opA[`XLEN-1] == opBInv[`XLEN-1]) && (diff[`XLEN-1] ^ opA[`XLEN-1]);

  assign flags.eq  = diff == '0;
  assign flags.lt  = diff[`XLEN-1] ^ overflow;
  assign flags.ltu = !carry;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:   result = opA + opB;
      aluSub:   result = diff;
      aluSll:   result = opA << shamt;
      aluSlt:   result = {{(`XLEN-1){1'b0}}, flags.lt};
      aluSltu:  result = {{(`XLEN-1){1'b0}}, flags.ltu};
      aluXor:   result = opA ^ opB;
      aluSrl:   result = opA >> shamt;
      aluSra:   result = $signed(opA) >>> shamt;
      aluOr:    result = opA | opB;
      aluAnd:   result = opA & opB;
      aluPassB: result = opB;
      default:  result = '0;
    endcase
  end

endmodule

/* logic/loadStoreUnit.sv */
`include "rvCore_settings.svh"

module loadStoreUnit (
  input  rvCorePkg::ctrlS    ctrl,
  input  logic               rst,
  input  logic [`XLEN-1:0]   addr,
  input  logic [`XLEN-1:0]   storeData,
  input  logic [`XLEN-1:0]   dmemRdData,
  output logic [`XLEN-1:0]   dmemAddr,
  output logic [`XLEN-1:0]   dmemWrData,
  output logic [`STRB_W-1:0] dmemWrStrb,
  output logic               dmemWrEn,
  output logic [`XLEN-1:0]   loadData
);
  import rvCorePkg::*;

  logic [2:0]         byteOff;
  logic [5:0]         bitOff;
  logic [`STRB_W-1:0] sizeStrb;
  logic [`XLEN-1:0]   rdShifted;
  logic [`XLEN-1:0]   extended;

  assign byteOff  = addr[2:0];
  assign bitOff   = {byteOff, 3'b000};
  assign dmemAddr = {addr[`XLEN-1:3], 3'b000};

  always_comb begin
    case (ctrl.memSize)
      memByte: sizeStrb = 8'h01;
      memHalf: sizeStrb = 8'h03;
      memWord: sizeStrb = 8'h0f;
      default: sizeStrb = 8'hff;
    endcase
  end

  // store lanes
  assign dmemWrEn   = ctrl.memWrite && !rst;
  assign dmemWrData = storeData << bitOff;
  assign dmemWrStrb = dmemWrEn ? sizeStrb << byteOff : '0;

  // load extract, addressed byte moved to lane 0
  assign rdShifted = dmemRdData >> bitOff;

  always_comb begin
    case (ctrl.memSize)
      memByte: extended = ctrl.memUnsigned ?
                          {{(`XLEN-8){1'b0}}, rdShifted[7:0]} :
                          {{(`XLEN-8){rdShifted[7]}}, rdShifted[7:0]};
      memHalf: extended = ctrl.memUnsigned ?
                          {{(`XLEN-16){1'b0}}, rdShifted[15:0]} :
                          {{(`XLEN-16){rdShifted[15]}}, rdShifted[15:0]};
      memWord: extended = ctrl.memUnsigned ?
                          {{(`XLEN-32){1'b0}}, rdShifted[31:0]} :
                          {{(`XLEN-32){rdShifted[31]}}, rdShifted[31:0]};
      default: extended = rdShifted;
    endcase
  end

  assign loadData = ctrl.memRead ? extended : '0;

endmodule

/* logic/pcUnit.sv */
`include "rvCore_settings.svh"

module pcUnit (
  input  logic                clk,
  input  logic                rst,
  input  rvCorePkg::brKindE   brKind,
  input  rvCorePkg::cmpFlagsS flags,
  input  logic [`XLEN-1:0]    imm,
  input  logic [`XLEN-1:0]    jumpTarget,
  output logic [`XLEN-1:0]    pc,
  output logic [`XLEN-1:0]    pcPlus4
);
  import rvCorePkg::*;

  logic             taken;
  logic [`XLEN-1:0] pcNext;

  assign pcPlus4 = pc + `XLEN'(4);

  always_comb begin
    case (brKind)
      brEq:    taken = flags.eq;
      brNe:    taken = !flags.eq;
      brLt:    taken = flags.lt;
      brGe:    taken = !flags.lt;
      brLtu:   taken = flags.ltu;
      brGeu:   taken = !flags.ltu;
      brJal:   taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (brKind == brJalr) begin
      pcNext = {jumpTarget[`XLEN-1:1], 1'b0};
    end else if (taken) begin
      pcNext = pc + imm;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

/* logic/regFile.sv */
`include "rvCore_settings.svh"

module regFile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic                  wrEn,
  input  logic [`XLEN-1:0]      wrData,
  output logic [`XLEN-1:0]      rs1Data,
  output logic [`XLEN-1:0]      rs2Data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 may hold anything, the read side hides it
  always_ff @(posedge clk) begin
    if (wrEn && !rst) begin
      regs[rd] <= wrData;
    end
  end

  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/rvCore.sv */
`include "rvCore_settings.svh"

module rvCore (
  input  logic               clk,
  input  logic               rst,
  input  logic [`ILEN-1:0]   imemData,
  input  logic [`XLEN-1:0]   dmemRdData,
  output logic [`XLEN-1:0]   imemAddr,
  output logic [`XLEN-1:0]   dmemAddr,
  output logic [`XLEN-1:0]   dmemWrData,
  output logic [`STRB_W-1:0] dmemWrStrb,
  output logic               dmemWrEn
);
  import rvCorePkg::*;

  instWordU                inst;
  ctrlS                    ctrl;
  cmpFlagsS                flags;
  logic [`XLEN-1:0]        imm;
  logic [`REG_IDX_W-1:0]   rs1Idx;
  logic [`REG_IDX_W-1:0]   rs2Idx;
  logic [`REG_IDX_W-1:0]   rdIdx;
  logic [`XLEN-1:0]        rs1Data;
  logic [`XLEN-1:0]        rs2Data;
  logic [`XLEN-1:0]        aluResult;
  logic [`XLEN-1:0]        pc;
  logic [`XLEN-1:0]        pcPlus4;
  logic [`XLEN-1:0]        loadData;
  logic [`XLEN-1:0]        wbData;

  assign inst     = imemData;
  assign imemAddr = pc;

  instDecoder u_instDecoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1Idx),
    .rs2  (rs2Idx),
    .rd   (rdIdx)
  );

  regFile u_regFile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1Idx),
    .rs2     (rs2Idx),
    .rd      (rdIdx),
    .wrEn    (ctrl.regWrite),
    .wrData  (wbData),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  intAlu u_intAlu (
    .ctrl    (ctrl),
    .pc      (pc),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .imm     (imm),
    .result  (aluResult),
    .flags   (flags)
  );

  // aluResult doubles as the JALR target
  pcUnit u_pcUnit (
    .clk        (clk),
    .rst        (rst),
    .brKind     (ctrl.brKind),
    .flags      (flags),
    .imm        (imm),
    .jumpTarget (aluResult),
    .pc         (pc),
    .pcPlus4    (pcPlus4)
  );

  loadStoreUnit u_loadStoreUnit (
    .ctrl       (ctrl),
    .rst        (rst),
    .addr       (aluResult),
    .storeData  (rs2Data),
    .dmemRdData (dmemRdData),
    .dmemAddr   (dmemAddr),
    .dmemWrData (dmemWrData),
    .dmemWrStrb (dmemWrStrb),
    .dmemWrEn   (dmemWrEn),
    .loadData   (loadData)
  );

  always_comb begin
    case (ctrl.wbSel)
      wbPcPlus4: wbData = pcPlus4;
      wbLoad:    wbData = loadData;
      default:   wbData = aluResult;
    endcase
  end

endmodule

/* logic/rvCorePkg.sv */
package rvCorePkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeE;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    f3AddSub = 3'd0,
    f3Sll    = 3'd1,
    f3Slt    = 3'd2,
    f3Sltu   = 3'd3,
    f3Xor    = 3'd4,
    f3SrlSra = 3'd5,
    f3Or     = 3'd6,
    f3And    = 3'd7
  } aluF3E;

  // funct3 of BRANCH, 2 and 3 are reserved
  typedef enum logic [2:0] {
    f3Beq  = 3'd0,
    f3Bne  = 3'd1,
    f3Blt  = 3'd4,
    f3Bge  = 3'd5,
    f3Bltu = 3'd6,
    f3Bgeu = 3'd7
  } brF3E;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluPassB
  } aluOpE;

  typedef enum logic [3:0] {
    brNone, brEq, brNe, brLt, brGe, brLtu, brGeu, brJal, brJalr
  } brKindE;

  typedef enum logic [1:0] {
    wbAlu, wbPcPlus4, wbLoad
  } wbSelE;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    memByte, memHalf, memWord, memDouble
  } memSizeE;

  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rTypeS;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeS;

  typedef struct packed {
    logic [6:0]  immHi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  immLo;
    logic [6:0]  opcode;
  } sTypeS;

  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10to5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4to1;
    logic        imm11;
    logic [6:0]  opcode;
  } bTypeS;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeS;

  typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10to1;
    logic        imm11;
    logic [7:0]  imm19to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } jTypeS;

  // one instruction word, viewed per format
  typedef union packed {
    rTypeS r;
    iTypeS i;
    sTypeS s;
    bTypeS b;
    uTypeS u;
    jTypeS j;
  } instWordU;

  typedef struct packed {
    aluOpE   aluOp;
    logic    srcAPc;
    logic    srcBImm;
    brKindE  brKind;
    wbSelE   wbSel;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    memSizeE memSize;
    logic    memUnsigned;
  } ctrlS;

  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } cmpFlagsS;

endpackage

/* logic/rvCore_settings.svh */
`ifndef RVCORE_SETTINGS_SVH
`define RVCORE_SETTINGS_SVH

// register and data width
`define XLEN 64

// instruction width
`define ILEN 32

`define REG_COUNT 32
`define REG_IDX_W 5

// first fetch after reset
`define RESET_PC 64'h0000_0000_8000_0000

// bytes per data word
`define STRB_W 8

`endif

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module rvCoreTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1

/* tb/rvCoreTb.sv */
`include "rvCore_settings.svh"

module rvCoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ImemWords = 256;
  localparam int DmemWords = 256;
  localparam int MaxCycles = 2000;
  localparam logic [63:0] MarkAddr = 64'h7f8;
  localparam logic [63:0] BadAddr = 64'h7f0;

  logic               clk;
  logic               rst;
  logic [`ILEN-1:0]   imemData;
  logic [`XLEN-1:0]   dmemRdData;
  logic [`XLEN-1:0]   imemAddr;
  logic [`XLEN-1:0]   dmemAddr;
  logic [`XLEN-1:0]   dmemWrData;
  logic [`STRB_W-1:0] dmemWrStrb;
  logic               dmemWrEn;

  logic [31:0] imem [ImemWords];
  logic [63:0] dmem [DmemWords];

  string       expName [$];
  logic [63:0] expAddr [$];
  logic [63:0] expData [$];
  logic [7:0]  expStrb [$];

  int          pcCount;
  logic [11:0] nextSlot;
  int          errors;
  int          storesSeen;
  int          cycles;
  int          seed;
  logic        doneSeen;
  logic [63:0] opA;
  logic [63:0] opB;
  logic [63:0] opC;
  logic [63:0] pcMark;
  logic [63:0] laneMask;
  string       curName;
  logic [63:0] curAddr;
  logic [63:0] curData;
  logic [7:0]  curStrb;

  rvCore u_rvCore (
    .clk        (clk),
    .rst        (rst),
    .imemData   (imemData),
    .dmemRdData (dmemRdData),
    .imemAddr   (imemAddr),
    .dmemAddr   (dmemAddr),
    .dmemWrData (dmemWrData),
    .dmemWrStrb (dmemWrStrb),
    .dmemWrEn   (dmemWrEn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fetch outside the program image returns addi x0,x0,0
  always_comb begin
    logic [63:0] wordIdx;
    wordIdx = (imemAddr - `RESET_PC) >> 2;
    imemData = (wordIdx < 64'(ImemWords)) ? imem[wordIdx[7:0]] : 32'h0000_0013;
  end

  always_comb begin
    dmemRdData = (dmemAddr < 64'h800) ? dmem[dmemAddr[10:3]] : '0;
  end

  always @(posedge clk) begin
    if (dmemWrEn && dmemAddr < 64'h800) begin
      for (int b = 0; b < 8; b++) begin
        if (dmemWrStrb[b]) begin
          dmem[dmemAddr[10:3]][b*8 +: 8] <= dmemWrData[b*8 +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] word);
    imem[pcCount] = word;
    pcCount++;
  endtask

  task automatic expectStore(input string name, input logic [63:0] addr,
                             input logic [7:0] strb, input logic [63:0] data);
    expName.push_back(name);
    expAddr.push_back(addr);
    expStrb.push_back(strb);
    expData.push_back(data);
  endtask

  // sd rs into the next free result slot, base x0
  task automatic storeResult(input string name, input logic [4:0] rs,
                             input logic [63:0] value);
    put(encS(nextSlot, rs, 3'd3));
    expectStore(name, 64'(nextSlot), 8'hff, value);
    nextSlot = nextSlot + 12'd8;
  endtask

  task automatic aluReg(input string name, input logic [6:0] f7, input logic [2:0] f3,
                        input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic [63:0] value);
    put(encR(f7, rs2, rs1, f3, 5'd5));
    storeResult(name, 5'd5, value);
  endtask

  task automatic aluImm(input string name, input logic [11:0] imm, input logic [2:0] f3,
                        input logic [4:0] rs1, input logic [63:0] value);
    put(encI(imm, rs1, f3, 5'd5, 7'b0010011));
    storeResult(name, 5'd5, value);
  endtask

  task automatic loadBack(input string name, input logic [2:0] f3, input logic [11:0] addr,
                          input logic [63:0] value);
    put(encI(addr, 5'd0, f3, 5'd6, 7'b0000011));
    storeResult(name, 5'd6, value);
  endtask

  // a taken branch jumps over the marker store
  task automatic branchOver(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic taken);
    put(encB(13'd8, rs2, rs1, f3));
    if (taken) begin
      put(encS(BadAddr[11:0], 5'd0, 3'd3));
    end else begin
      storeResult(name, 5'd1, opA);
    end
  endtask

  task automatic buildProgram();
    pcCount = 0;
    nextSlot = 12'h100;
    // store fetched while rst is high
    storeResult("reset pc store", 5'd0, 64'd0);
    put(encI(12'd0, 5'd0, 3'd3, 5'd1, 7'b0000011));
    put(encI(12'd8, 5'd0, 3'd3, 5'd2, 7'b0000011));
    put(encI(12'd16, 5'd0, 3'd3, 5'd3, 7'b0000011));
    aluReg("add", 7'h00, 3'd0, 5'd1, 5'd2, opA + opB);
    aluReg("sub", 7'h20, 3'd0, 5'd1, 5'd2, opA - opB);
    aluReg("sll", 7'h00, 3'd1, 5'd1, 5'd2, opA << opB[5:0]);
    aluReg("slt neg", 7'h00, 3'd2, 5'd3, 5'd1, {63'd0, $signed(opC) < $signed(opA)});
    aluReg("slt pos", 7'h00, 3'd2, 5'd1, 5'd3, {63'd0, $signed(opA) < $signed(opC)});
    aluReg("sltu", 7'h00, 3'd3, 5'd1, 5'd3, {63'd0, opA < opC});
    aluReg("xor", 7'h00, 3'd4, 5'd1, 5'd2, opA ^ opB);
    aluReg("srl", 7'h00, 3'd5, 5'd3, 5'd2, opC >> opB[5:0]);
    aluReg("sra", 7'h20, 3'd5, 5'd3, 5'd2, 64'($signed(opC) >>> opB[5:0]));
    aluReg("or", 7'h00, 3'd6, 5'd1, 5'd2, opA | opB);
    aluReg("and", 7'h00, 3'd7, 5'd1, 5'd2, opA & opB);
    aluImm("addi", 12'hffb, 3'd0, 5'd1, opA - 64'd5);
    aluImm("slti", 12'd7, 3'd2, 5'd3, {63'd0, $signed(opC) < 64'sd7});
    aluImm("sltiu", 12'hfff, 3'd3, 5'd1, {63'd0, opA < 64'hffff_ffff_ffff_ffff});
    aluImm("xori", 12'h8f0, 3'd4, 5'd1, opA ^ 64'hffff_ffff_ffff_f8f0);
    aluImm("ori", 12'h0f0, 3'd6, 5'd2, opB | 64'h0f0);
    aluImm("andi", 12'h7c3, 3'd7, 5'd3, opC & 64'h7c3);
    aluImm("slli", 12'd13, 3'd1, 5'd1, opA << 13);
    aluImm("srli", 12'd7, 3'd5, 5'd3, opC >> 7);
    aluImm("srai", 12'h409, 3'd5, 5'd3, 64'($signed(opC) >>> 9));
    // x0 ignores the write
    put(encI(12'd5, 5'd1, 3'd0, 5'd0, 7'b0010011));
    storeResult("x0 write", 5'd0, 64'd0);
    put(encS(12'h601, 5'd2, 3'd0));
    expectStore("sb lane", 64'h600, 8'h02, opB << 8);
    put(encS(12'h60a, 5'd1, 3'd1));
    expectStore("sh lane", 64'h608, 8'h0c, opA << 16);
    put(encS(12'h614, 5'd3, 3'd2));
    expectStore("sw lane", 64'h610, 8'hf0, opC << 32);
    loadBack("lb pos", 3'd0, 12'd1, {{56{opA[15]}}, opA[15:8]});
    loadBack("lb", 3'd0, 12'd23, {{56{opC[63]}}, opC[63:56]});
    loadBack("lbu", 3'd4, 12'd23, {56'd0, opC[63:56]});
    loadBack("lh", 3'd1, 12'd22, {{48{opC[63]}}, opC[63:48]});
    loadBack("lhu", 3'd5, 12'd22, {48'd0, opC[63:48]});
    loadBack("lw", 3'd2, 12'd20, {{32{opC[63]}}, opC[63:32]});
    loadBack("lwu", 3'd6, 12'd20, {32'd0, opC[63:32]});
    loadBack("ld", 3'd3, 12'd8, opB);
    // x1 is positive and x3 negative, so every outcome is fixed
    branchOver("beq", 3'd0, 5'd1, 5'd1, 1'b1);
    branchOver("beq not taken", 3'd0, 5'd1, 5'd2, 1'b0);
    branchOver("bne", 3'd1, 5'd1, 5'd2, 1'b1);
    branchOver("bne not taken", 3'd1, 5'd1, 5'd1, 1'b0);
    branchOver("blt", 3'd4, 5'd3, 5'd1, 1'b1);
    branchOver("blt not taken", 3'd4, 5'd1, 5'd3, 1'b0);
    branchOver("bge", 3'd5, 5'd1, 5'd3, 1'b1);
    branchOver("bge not taken", 3'd5, 5'd3, 5'd1, 1'b0);
    branchOver("bltu", 3'd6, 5'd1, 5'd3, 1'b1);
    branchOver("bltu not taken", 3'd6, 5'd3, 5'd1, 1'b0);
    branchOver("bgeu", 3'd7, 5'd3, 5'd1, 1'b1);
    branchOver("bgeu not taken", 3'd7, 5'd1, 5'd3, 1'b0);
    pcMark = `RESET_PC + 64'(4 * pcCount);
    put(encJ(21'd8, 5'd8));
    put(encS(BadAddr[11:0], 5'd0, 3'd3));
    storeResult("jal link", 5'd8, pcMark + 64'd4);
    pcMark = `RESET_PC + 64'(4 * pcCount);
    put(encU(20'd0, 5'd9, 7'b0010111));
    storeResult("auipc zero", 5'd9, pcMark);
    // odd offset, bit 0 of the target is dropped
    put(encI(12'd17, 5'd9, 3'd0, 5'd10, 7'b1100111));
    put(encS(BadAddr[11:0], 5'd0, 3'd3));
    storeResult("jalr link", 5'd10, pcMark + 64'd12);
    put(encU(20'h87654, 5'd11, 7'b0110111));
    storeResult("lui", 5'd11, 64'hffff_ffff_8765_4000);
    pcMark = `RESET_PC + 64'(4 * pcCount);
    put(encU(20'h12345, 5'd12, 7'b0010111));
    storeResult("auipc", 5'd12, pcMark + 64'h1234_5000);
    put(encI(12'h5a5, 5'd0, 3'd0, 5'd13, 7'b0010011));
    put(encS(MarkAddr[11:0], 5'd13, 3'd3));
    expectStore("final marker", MarkAddr, 8'hff, 64'h5a5);
    put(encJ(21'd0, 5'd0));
  endtask

  function automatic logic [63:0] maskOf(input logic [7:0] strb);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[b*8 +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (!rst && dmemWrEn) begin
      storesSeen++;
      if (expName.size() == 0) begin
        errors++;
        $display("store to %h happened after all expected stores", dmemAddr);
      end else begin
        curName = expName.pop_front();
        curAddr = expAddr.pop_front();
        curStrb = expStrb.pop_front();
        curData = expData.pop_front();
        laneMask = maskOf(curStrb);
        storeOk: assert (dmemAddr == curAddr && dmemWrStrb == curStrb &&
                         (dmemWrData & laneMask) == (curData & laneMask))
        else begin
          errors++;
          $display("ERROR %s expected addr %h strb %h data %h, actual addr %h strb %h data %h",
                   curName, curAddr, curStrb, curData & laneMask,
                   dmemAddr, dmemWrStrb, dmemWrData & laneMask);
        end
      end
      if (dmemAddr == MarkAddr) begin
        doneSeen = 1'b1;
      end
    end
  end

  initial begin
    rst = 1'b1;
    errors = 0;
    storesSeen = 0;
    doneSeen = 1'b0;
    seed = 32'h4bbb_7c9c;
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = 32'h0000_0013;
    end
    for (int i = 0; i < DmemWords; i++) begin
      dmem[i] = {32'(i) ^ 32'hc3a5_0000, ~32'(i)};
    end
    opA = {$random(seed), $random(seed)};
    opB = {$random(seed), $random(seed)};
    opC = {$random(seed), $random(seed)};
    opA[63] = 1'b0;
    opC[63] = 1'b1;
    dmem[0] = opA;
    dmem[1] = opB;
    dmem[2] = opC;
    buildProgram();
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 0;
    while (!doneSeen && cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!doneSeen) begin
      errors++;
      $display("timeout waiting for the final marker store");
    end else if (expName.size() != 0) begin
      errors++;
      $display("%0d expected stores never happened", expName.size());
    end
    repeat (2) @(posedge clk);
    $display("stores checked %0d, errors %0d", storesSeen, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb/rvCore_chk.sv */
`include "rvCore_settings.svh"

module rvCoreChk (
  input logic               clk,
  input logic               rst,
  input logic [`XLEN-1:0]   imemAddr,
  input logic [`ILEN-1:0]   imemData,
  input logic               dmemWrEn,
  input logic [`STRB_W-1:0] dmemWrStrb
);
  timeunit 1ns;
  timeprecision 1ps;

  logic flowOp;

  // branches and jumps may leave the sequential path
  assign flowOp = imemData[6:0] == 7'b1100011 ||
                  imemData[6:0] == 7'b1101111 ||
                  imemData[6:0] == 7'b1100111;

  noStoreInReset: assert property (
    @(posedge clk) rst |-> !dmemWrEn
  ) else $error("store strobe raised while reset is active");

  pcAfterReset: assert property (
    @(posedge clk) $fell(rst) |-> imemAddr == `RESET_PC
  ) else $error("pc is not the reset address on the first cycle after reset");

  pcAligned: assert property (
    @(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00
  ) else $error("pc is not word aligned");

  pcSequential: assert property (
    @(posedge clk) disable iff (rst)
      !flowOp |=> imemAddr == $past(imemAddr) + `XLEN'(4)
  ) else $error("pc did not advance by 4 after a non-flow instruction");

  strobeMatchesEnable: assert property (
    @(posedge clk) (dmemWrStrb != '0) == dmemWrEn
  ) else $error("byte strobes and write enable disagree");

endmodule

bind rvCore rvCoreChk u_rvCoreChk (
  .clk        (clk),
  .rst        (rst),
  .imemAddr   (imemAddr),
  .imemData   (imemData),
  .dmemWrEn   (dmemWrEn),
  .dmemWrStrb (dmemWrStrb)
);

/* verilog.f */
+incdir+logic
logic/rvCorePkg.sv
logic/regFile.sv
logic/intAlu.sv
logic/pcUnit.sv
logic/loadStoreUnit.sv
logic/instDecoder.sv
logic/rvCore.sv
tb/rvCore_chk.sv
tb/rvCoreTb.sv
